// File: design/streamAlu_defs.svh
`ifndef STREAMALU_DEFS_SVH
`define STREAMALU_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Engine sizing.
//////////////////////////////////////////////////////////////////////

// Data path and command word width.
`define STREAMALU_DATA_WIDTH 16

// Working registers addressed by the 2-bit fields of a command.
`define STREAMALU_REG_COUNT 4

`define STREAMALU_FIFO_DEPTH 8 // Entries per queue.

`endif

// File: design/streamAluPkg.sv
`default_nettype none

`include "streamAlu_defs.svh"

package streamAluPkg;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SHL = 3'd5,
    MOV = 3'd6,
    NOP = 3'd7
  } aluOp_t;

  //////////////////////////////////////////////////////////////////////
  // Command word, bit 15 selects the view.
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        form;  // 1 for load.
    logic [1:0]  dest;
    logic [12:0] imm;
  } loadForm_t;

  typedef struct packed {
    logic       form;
    aluOp_t     op;
    logic [1:0] dest;
    logic [1:0] srcA;
    logic [1:0] srcB;
    logic [5:0] unused; // Nonzero marks a reserved encoding.
  } aluForm_t;

  typedef union packed {
    loadForm_t loadForm;
    aluForm_t  aluForm;
  } cmdWord_t;

  typedef struct packed {
    logic                             isLoad;
    aluOp_t                           op;
    logic [1:0]                       dest;
    logic [1:0]                       srcA;
    logic [1:0]                       srcB;
    logic [`STREAMALU_DATA_WIDTH-1:0] imm;
  } decodedOp_t;

  typedef struct packed {
    logic [3:0]                       seq;
    logic [1:0]                       dest;
    logic                             zero;
    logic [`STREAMALU_DATA_WIDTH-1:0] value;
  } result_t;

endpackage

`default_nettype wire

// File: design/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             CLK,
  input  logic             RESETN,
  input  logic [WIDTH-1:0] DIN,
  output logic [WIDTH-1:0] DOUT,
  input  logic             WE,
  input  logic             RE,
  output logic             NOT_EMPTY,
  output logic             FULL
);

  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int ACTUAL_DEPTH = 2 ** ADDR_WIDTH;
  localparam int PTR_WIDTH = ADDR_WIDTH + 1; // Extra bit tells full from empty.

  logic [WIDTH-1:0]     mem [ACTUAL_DEPTH];
  logic [PTR_WIDTH-1:0] wrPtr;
  logic [PTR_WIDTH-1:0] wrPtrNext;
  logic [PTR_WIDTH-1:0] rdPtr;
  logic [PTR_WIDTH-1:0] rdPtrNext;
  logic                 wrInc;
  logic                 rdInc;
  logic                 fullNext;
  logic                 notEmptyNext;

  assign wrInc = WE & ~FULL;      // Writes while full are dropped.
  assign rdInc = RE & NOT_EMPTY;

  assign wrPtrNext = wrPtr + PTR_WIDTH'(wrInc);
  assign rdPtrNext = rdPtr + PTR_WIDTH'(rdInc);

  assign fullNext = (wrPtrNext[ADDR_WIDTH] != rdPtrNext[ADDR_WIDTH]) &&
                    (wrPtrNext[ADDR_WIDTH-1:0] == rdPtrNext[ADDR_WIDTH-1:0]);
  assign notEmptyNext = (wrPtrNext != rdPtrNext);

  always_ff @(posedge CLK) begin
    if (wrInc) begin
      mem[wrPtr[ADDR_WIDTH-1:0]] <= DIN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Show-ahead output, the next head is loaded ahead of the read.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wrInc && (wrPtr[ADDR_WIDTH-1:0] == rdPtrNext[ADDR_WIDTH-1:0])) begin
      DOUT <= DIN; // Slot written now is the new head.
    end else begin
      DOUT <= mem[rdPtrNext[ADDR_WIDTH-1:0]];
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      FULL      <= 1'b0;
      NOT_EMPTY <= 1'b0;
    end else begin
      wrPtr     <= wrPtrNext;
      rdPtr     <= rdPtrNext;
      FULL      <= fullNext;
      NOT_EMPTY <= notEmptyNext;
    end
  end

endmodule

`default_nettype wire

// File: design/cmdDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "streamAlu_defs.svh"

module cmdDecoder import streamAluPkg::*; (
  input  logic       CLK,
  input  logic       RESETN,
  input  cmdWord_t   cmdHead,
  input  logic       cmdNotEmpty,
  input  logic       stall,
  output logic       cmdPop,
  output decodedOp_t decoded,
  output logic       decodedValid
);

  decodedOp_t decodedNext;

  // Pop only when this stage can move on.
  assign cmdPop = cmdNotEmpty & ~stall;

  always_comb begin
    decodedNext = '0;
    if (cmdHead.loadForm.form) begin
      decodedNext.isLoad = 1'b1;
      decodedNext.op     = NOP;
      decodedNext.dest   = cmdHead.loadForm.dest;
      decodedNext.imm    = {{(`STREAMALU_DATA_WIDTH - 13){1'b0}}, cmdHead.loadForm.imm};
    end else begin
      decodedNext.isLoad = 1'b0;
      decodedNext.dest   = cmdHead.aluForm.dest;
      decodedNext.srcA   = cmdHead.aluForm.srcA;
      decodedNext.srcB   = cmdHead.aluForm.srcB;
      // Reserved encodings fall back to NOP.
      if (cmdHead.aluForm.unused != '0) begin
        decodedNext.op = NOP;
      end else begin
        decodedNext.op = cmdHead.aluForm.op;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      decodedValid <= 1'b0;
    end else if (!stall) begin
      decodedValid <= cmdNotEmpty;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      decoded <= decodedNext;
    end
  end

endmodule

`default_nettype wire

// File: design/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

`include "streamAlu_defs.svh"

module aluExecute import streamAluPkg::*; (
  input  logic       CLK,
  input  logic       RESETN,
  input  decodedOp_t decoded,
  input  logic       decodedValid,
  input  logic       stall,
  output result_t    result,
  output logic       resultValid
);

  logic [`STREAMALU_DATA_WIDTH-1:0] workRegs [`STREAMALU_REG_COUNT];
  logic [`STREAMALU_DATA_WIDTH-1:0] opA;
  logic [`STREAMALU_DATA_WIDTH-1:0] opB;
  logic [`STREAMALU_DATA_WIDTH-1:0] aluValue;
  logic                             writeEnable;
  logic                             advance;

  assign opA = workRegs[decoded.srcA];
  assign opB = workRegs[decoded.srcB];

  assign advance = decodedValid & ~stall;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aluValue    = opA;
    writeEnable = 1'b1;
    if (decoded.isLoad) begin
      aluValue = decoded.imm;
    end else begin
      case (decoded.op)
        ADD: aluValue = opA + opB;       // Wraps modulo 2^16.
        SUB: aluValue = opA - opB;
        AND: aluValue = opA & opB;
        OR:  aluValue = opA | opB;
        XOR: aluValue = opA ^ opB;
        SHL: aluValue = opA << opB[3:0];
        MOV: aluValue = opA;
        default: writeEnable = 1'b0;     // NOP.
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      for (int i = 0; i < `STREAMALU_REG_COUNT; i++) begin
        workRegs[i] <= '0;
      end
    end else if (advance && writeEnable) begin
      workRegs[decoded.dest] <= aluValue;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      resultValid <= 1'b0;
    end else if (!stall) begin
      resultValid <= decodedValid & writeEnable;
    end
  end

  // Seq and zero are filled in by the result stage.
  always_ff @(posedge CLK) begin
    if (!stall) begin
      result.seq   <= '0;
      result.dest  <= decoded.dest;
      result.zero  <= 1'b0;
      result.value <= aluValue;
    end
  end

endmodule

`default_nettype wire

// File: design/resultPacker.sv
`timescale 1ns/1ps
`default_nettype none

module resultPacker import streamAluPkg::*; (
  input  logic    CLK,
  input  logic    RESETN,
  input  result_t result,
  input  logic    resultValid,
  input  logic    resFull,
  output logic    resWrite,
  output result_t resWord,
  output logic    stall
);

  logic [3:0] seqCount;

  assign resWrite = resultValid & ~resFull;
  assign stall    = resultValid & resFull;   // Holds the whole pipeline.

  always_comb begin
    resWord      = result;
    resWord.seq  = seqCount;
    resWord.zero = (result.value == '0);
  end

  // Counts accepted results, wraps at 16.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      seqCount <= '0;
    end else if (resWrite) begin
      seqCount <= seqCount + 4'd1;
    end
  end

endmodule

`default_nettype wire

// File: design/streamAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "streamAlu_defs.svh"

module streamAlu import streamAluPkg::*; (
  input  logic     CLK,
  input  logic     RESETN,
  input  cmdWord_t cmdData,
  input  logic     cmdWrite,
  output logic     cmdFull,
  output result_t  resData,
  input  logic     resRead,
  output logic     resNotEmpty
);

  cmdWord_t   cmdHead;
  logic       cmdNotEmpty;
  logic       cmdPop;
  decodedOp_t decoded;
  logic       decodedValid;
  result_t    aluResult;
  logic       aluResultValid;
  result_t    resWord;
  logic       resWrite;
  logic       resFull;
  logic       stall;

  //////////////////////////////////////////////////////////////////////
  // Command queue and decode.
  //////////////////////////////////////////////////////////////////////

  fifo #(
    .WIDTH(`STREAMALU_DATA_WIDTH),
    .DEPTH(`STREAMALU_FIFO_DEPTH)
  ) cmdFifo (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .DIN      (cmdData),
    .DOUT     (cmdHead),
    .WE       (cmdWrite),
    .RE       (cmdPop),
    .NOT_EMPTY(cmdNotEmpty),
    .FULL     (cmdFull)
  );

  cmdDecoder decoder (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .cmdHead     (cmdHead),
    .cmdNotEmpty (cmdNotEmpty),
    .stall       (stall),
    .cmdPop      (cmdPop),
    .decoded     (decoded),
    .decodedValid(decodedValid)
  );

  aluExecute execute (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .decoded     (decoded),
    .decodedValid(decodedValid),
    .stall       (stall),
    .result      (aluResult),
    .resultValid (aluResultValid)
  );

  //////////////////////////////////////////////////////////////////////
  // Result stage and queue.
  //////////////////////////////////////////////////////////////////////

  resultPacker packer (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .result     (aluResult),
    .resultValid(aluResultValid),
    .resFull    (resFull),
    .resWrite   (resWrite),
    .resWord    (resWord),
    .stall      (stall)
  );

  fifo #(
    .WIDTH($bits(result_t)),
    .DEPTH(`STREAMALU_FIFO_DEPTH)
  ) resFifo (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .DIN      (resWord),
    .DOUT     (resData),
    .WE       (resWrite),
    .RE       (resRead),
    .NOT_EMPTY(resNotEmpty),
    .FULL     (resFull)
  );

endmodule

`default_nettype wire

// File: testbench/streamAlu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module streamAlu_assertions import streamAluPkg::*; (
  input logic    CLK,
  input logic    RESETN,
  input logic    cmdWrite,
  input logic    cmdFull,
  input logic    cmdPop,
  input result_t resData,
  input logic    resRead,
  input logic    resNotEmpty
);

  int         violationCount = 0;
  logic [4:0] cmdOccupancy; // Commands accepted and not yet popped.

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      cmdOccupancy <= '0;
    end else begin
      cmdOccupancy <= cmdOccupancy + 5'(cmdWrite & ~cmdFull) - 5'(cmdPop);
    end
  end

  flagsLowAfterReset: assert property (@(posedge CLK) !RESETN |=> (!resNotEmpty && !cmdFull))
    else begin
      violationCount++;
      $error("Queue flags not low after reset.");
    end

  // Head word holds until it is read.
  headStable: assert property (@(posedge CLK) disable iff (!RESETN)
    (resNotEmpty && !resRead) |=> $stable(resData))
    else begin
      violationCount++;
      $error("Result head changed without a read.");
    end

  noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!RESETN)
    cmdPop |-> (cmdOccupancy != 5'd0))
    else begin
      violationCount++;
      $error("Command queue popped while empty.");
    end

endmodule

bind streamAlu streamAlu_assertions protocolChecks (
  .CLK        (CLK),
  .RESETN     (RESETN),
  .cmdWrite   (cmdWrite),
  .cmdFull    (cmdFull),
  .cmdPop     (cmdPop),
  .resData    (resData),
  .resRead    (resRead),
  .resNotEmpty(resNotEmpty)
);

`default_nettype wire

// File: testbench/streamAlu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "streamAlu_defs.svh"

module streamAlu_tb import streamAluPkg::*; ();

  localparam int TIMEOUT_CYCLES = 5000; // Tests need under 1000 cycles, random stream the most.
  localparam int PIPE_CAPACITY = 2 * `STREAMALU_FIFO_DEPTH + 2; // Two queues plus two stages.

  logic     CLK;
  logic     RESETN;
  cmdWord_t cmdData;
  logic     cmdWrite;
  logic     cmdFull;
  result_t  resData;
  logic     resRead;
  logic     resNotEmpty;

  logic [`STREAMALU_DATA_WIDTH-1:0] modelRegs [`STREAMALU_REG_COUNT];
  logic [3:0]  modelSeq;
  result_t     expected [$];
  logic [16:0] lfsrState;
  int          cycleCount = 0;

  streamAlu dut (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .cmdData    (cmdData),
    .cmdWrite   (cmdWrite),
    .cmdFull    (cmdFull),
    .resData    (resData),
    .resRead    (resRead),
    .resNotEmpty(resNotEmpty)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      failWith("timeout, the tests did not finish within the cycle limit");
    end else if (dut.protocolChecks.violationCount != 0) begin
      failWith("a protocol assertion on the DUT did not hold");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and stimulus helpers.
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic failWith(input string why);
    $display("ERROR: %s", why);
    abortRun();
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expectedValue);
    if (actual !== expectedValue) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expectedValue);
      abortRun();
    end
  endtask

  // Taps 17 and 14.
  function automatic logic [16:0] lfsrNext(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic takeBits(input int count, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits = {bits[14:0], lfsrState[0]};
    end
  endtask

  function automatic cmdWord_t loadCmd(input logic [1:0] dest, input logic [12:0] imm);
    cmdWord_t word;
    word.loadForm.form = 1'b1;
    word.loadForm.dest = dest;
    word.loadForm.imm  = imm;
    return word;
  endfunction

  function automatic cmdWord_t aluCmd(input aluOp_t op, input logic [1:0] dest,
                                      input logic [1:0] srcA, input logic [1:0] srcB);
    cmdWord_t word;
    word.aluForm.form   = 1'b0;
    word.aluForm.op     = op;
    word.aluForm.dest   = dest;
    word.aluForm.srcA   = srcA;
    word.aluForm.srcB   = srcB;
    word.aluForm.unused = 6'd0;
    return word;
  endfunction

  // About one ALU word in sixteen keeps nonzero unused bits.
  task automatic randomCmd(output cmdWord_t word);
    logic [15:0] bits;
    logic [15:0] choice;
    takeBits(16, bits);
    takeBits(4, choice);
    word = bits;
    if (!word.aluForm.form && choice[3:0] != 4'd0) begin
      word.aluForm.unused = 6'd0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model, one entry per accepted command.
  //////////////////////////////////////////////////////////////////////

  task automatic modelAccept(input cmdWord_t word);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] value;
    logic [1:0]  dest;
    logic        produces;
    result_t     item;
    produces = 1'b1;
    if (word.loadForm.form) begin
      dest  = word.loadForm.dest;
      value = {3'b000, word.loadForm.imm};
    end else begin
      dest  = word.aluForm.dest;
      a     = modelRegs[word.aluForm.srcA];
      b     = modelRegs[word.aluForm.srcB];
      value = 16'h0000;
      case (word.aluForm.op)
        ADD: value = a + b;
        SUB: value = a - b;
        AND: value = a & b;
        OR:  value = a | b;
        XOR: value = a ^ b;
        SHL: value = a << b[3:0];
        MOV: value = a;
        default: produces = 1'b0;
      endcase
      if (word.aluForm.unused != 6'd0) begin
        produces = 1'b0; // Reserved.
      end
    end
    if (produces) begin
      modelRegs[dest] = value;
      item.seq   = modelSeq;
      item.dest  = dest;
      item.zero  = (value == 16'h0000);
      item.value = value;
      expected.push_back(item);
      modelSeq = modelSeq + 4'd1;
    end
  endtask

  // Drives one edge, then samples at the falling edge.
  task automatic stepCycle(input logic doWrite, input cmdWord_t word, input logic doRead,
                           output logic accepted);
    result_t head;
    @(posedge CLK);
    cmdWrite <= doWrite;
    cmdData  <= word;
    resRead  <= doRead;
    @(negedge CLK);
    accepted = doWrite && !cmdFull;
    if (doRead && resNotEmpty) begin
      if (expected.size() == 0) begin
        failWith("a result arrived while no result was pending");
      end else begin
        head = expected.pop_front();
        checkValue("resData.seq", resData.seq, head.seq);
        checkValue("resData.dest", resData.dest, head.dest);
        checkValue("resData.zero", resData.zero, head.zero);
        checkValue("resData.value", resData.value, head.value);
      end
    end
    if (accepted) begin
      modelAccept(word);
    end
  endtask

  task automatic sendCmd(input cmdWord_t word);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      stepCycle(1'b1, word, 1'b1, accepted);
    end
  endtask

  task automatic drainResults();
    logic accepted;
    while (expected.size() != 0) begin
      stepCycle(1'b0, '0, 1'b1, accepted);
    end
    repeat (6) stepCycle(1'b0, '0, 1'b1, accepted); // Longer than the pipeline.
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests.
  //////////////////////////////////////////////////////////////////////

  task automatic testReset();
    @(negedge CLK);
    checkValue("cmdFull", cmdFull, 0);
    checkValue("resNotEmpty", resNotEmpty, 0);
  endtask

  task automatic testAluOps();
    sendCmd(loadCmd(2'd0, 13'h1234));
    sendCmd(loadCmd(2'd1, 13'h0F0F));
    sendCmd(loadCmd(2'd2, 13'h0003));
    sendCmd(loadCmd(2'd3, 13'h1FFF));
    sendCmd(aluCmd(ADD, 2'd0, 2'd0, 2'd1));
    sendCmd(aluCmd(SUB, 2'd2, 2'd2, 2'd3)); // Goes below zero.
    sendCmd(aluCmd(AND, 2'd1, 2'd0, 2'd1));
    sendCmd(aluCmd(OR, 2'd3, 2'd1, 2'd2));
    sendCmd(aluCmd(XOR, 2'd0, 2'd3, 2'd3)); // Zero result.
    sendCmd(aluCmd(SHL, 2'd1, 2'd1, 2'd2));
    sendCmd(aluCmd(MOV, 2'd3, 2'd1, 2'd0));
    drainResults();
  endtask

  task automatic testNopReserved();
    cmdWord_t reserved;
    reserved = aluCmd(ADD, 2'd1, 2'd0, 2'd0);
    reserved.aluForm.unused = 6'h21;
    sendCmd(loadCmd(2'd1, 13'h0ABC));
    sendCmd(aluCmd(NOP, 2'd1, 2'd0, 2'd0));
    sendCmd(reserved);
    sendCmd(aluCmd(MOV, 2'd2, 2'd1, 2'd1));
    drainResults();
  endtask

  task automatic testLatency();
    logic accepted;
    stepCycle(1'b1, loadCmd(2'd3, 13'h0055), 1'b0, accepted);
    checkValue("write accepted", accepted, 1);
    for (int k = 1; k <= 4; k++) begin
      stepCycle(1'b0, '0, 1'b0, accepted);
      checkValue("resNotEmpty", resNotEmpty, k == 4);
    end
    drainResults();
  endtask

  task automatic testBackpressure();
    cmdWord_t word;
    logic     accepted;
    int       count;
    count    = 0;
    accepted = 1'b1;
    while (accepted) begin
      if (count % 3 == 2) begin
        word = aluCmd(ADD, 2'd0, 2'd0, 2'd1);
      end else begin
        word = loadCmd(2'(count), 13'(count * 7));
      end
      stepCycle(1'b1, word, 1'b0, accepted);
      if (accepted) begin
        count++;
      end
    end
    checkValue("accepted commands", count, PIPE_CAPACITY);
    drainResults();
  endtask

  task automatic testRandomStream();
    cmdWord_t    word;
    logic [15:0] gate;
    logic        accepted;
    for (int n = 0; n < 200; n++) begin
      randomCmd(word);
      accepted = 1'b0;
      while (!accepted) begin
        takeBits(1, gate);
        stepCycle(1'b1, word, gate[0], accepted);
      end
    end
    drainResults();
  endtask

  initial begin
    RESETN    = 1'b0;
    cmdWrite  = 1'b0;
    cmdData   = '0;
    resRead   = 1'b0;
    lfsrState = 17'd86648;
    modelSeq  = '0;
    for (int i = 0; i < `STREAMALU_REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end
    repeat (4) @(posedge CLK);
    RESETN <= 1'b1;
    testReset();
    testAluOps();
    testNopReserved();
    testLatency();
    testBackpressure();
    testRandomStream();
    if (dut.protocolChecks.violationCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      failWith("assertions reported errors during the run");
    end
  end

endmodule

`default_nettype wire

// File: streamAlu.f
+incdir+design
design/streamAluPkg.sv
design/fifo.sv
design/cmdDecoder.sv
design/aluExecute.sv
design/resultPacker.sv
design/streamAlu.sv
testbench/streamAlu_assertions.sv
testbench/streamAlu_tb.sv

// File: Bender.yml
package:
  name: streamAlu

export_include_dirs:
  - design

sources:
  - design/streamAluPkg.sv
  - design/fifo.sv
  - design/cmdDecoder.sv
  - design/aluExecute.sv
  - design/resultPacker.sv
  - design/streamAlu.sv
  - target: test
    files:
      - testbench/streamAlu_assertions.sv
      - testbench/streamAlu_tb.sv
